// ==== rv_pipe_pkg.sv ====
package rv_pipe_pkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////
	localparam int xlen       = 32;              // Data path width
	localparam int pc_w       = 12;              // 4 KB program space
	localparam int dmem_aw    = 10;              // Data memory word address
	localparam int dmem_depth = 1 << dmem_aw;    // 1024 words
	localparam int imem_depth = 1024;            // ROM words

	typedef logic [xlen-1:0]    word_t;
	typedef logic [pc_w-1:0]    pc_t;            // Byte address of an instruction
	typedef logic [4:0]         reg_idx_t;
	typedef logic [dmem_aw-1:0] dmem_addr_t;
	typedef logic [3:0]         byte_en_t;       // One bit per byte lane

	// Load and store width, same values as funct3
	typedef logic [2:0] mem_size_t;
	localparam mem_size_t size_b  = 3'b000;
	localparam mem_size_t size_h  = 3'b001;
	localparam mem_size_t size_w  = 3'b010;
	localparam mem_size_t size_bu = 3'b100;
	localparam mem_size_t size_hu = 3'b101;

	// ALU codes are {funct7[5], funct3} so the decoder can build them directly
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000,
		alu_sra  = 4'b1101
	} alu_op_t;

	// Write-back source
	typedef enum logic [1:0] {
		wb_pc4  = 2'd0,
		wb_alu  = 2'd1,
		wb_imm  = 2'd2,
		wb_load = 2'd3
	} wb_sel_t;

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////
	localparam logic [6:0] op_rtype = 7'b0110011;
	localparam logic [6:0] op_itype = 7'b0010011;
	localparam logic [6:0] op_load  = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_lui   = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;

endpackage

// ==== dmem_port_if.sv ====
`timescale 1ns/1ps

// Core side of the data memory
interface dmem_port_if;
	rv_pipe_pkg::dmem_addr_t addr;      // Word address
	rv_pipe_pkg::word_t      wdata;     // Lane-replicated store data
	rv_pipe_pkg::byte_en_t   byte_we;   // Nonzero means write on the edge
	rv_pipe_pkg::word_t      rdata;     // Follows addr, no clock

	modport cpu (
		output addr, wdata, byte_we,
		input  rdata
	);

	modport mem (
		input  addr, wdata, byte_we,
		output rdata
	);
endinterface

// ==== decoder.sv ====
`timescale 1ns/1ps

module decoder (
	input  rv_pipe_pkg::word_t     inst,
	output rv_pipe_pkg::alu_op_t   alu_op,
	output logic                   sel_opa,    // 1 rs1, 0 PC
	output logic                   sel_opb,    // 1 immediate, 0 rs2
	output logic                   wr_en,
	output logic                   is_store,
	output rv_pipe_pkg::mem_size_t mem_size,
	output rv_pipe_pkg::wb_sel_t   wb_sel,
	output rv_pipe_pkg::word_t     imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       f7_alt;                      // funct7 bit 5, sub and sra
	rv_pipe_pkg::word_t imm_i, imm_s, imm_u;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign f7_alt = inst[30];

	// Immediate formats
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_u = {inst[31:12], 12'b0};

	always_comb begin
		alu_op   = rv_pipe_pkg::alu_add;
		sel_opa  = 1'b1;
		sel_opb  = 1'b1;
		wr_en    = 1'b0;                     // Unknown opcode ends as no-op
		is_store = 1'b0;
		mem_size = funct3;
		wb_sel   = rv_pipe_pkg::wb_alu;
		imm      = imm_i;
		case (opcode)
			rv_pipe_pkg::op_rtype: begin
				alu_op  = rv_pipe_pkg::alu_op_t'({f7_alt, funct3});
				sel_opb = 1'b0;
				wr_en   = 1'b1;
			end
			rv_pipe_pkg::op_itype: begin
				// Bit 30 is only an opcode bit for the shift-right pair
				alu_op = rv_pipe_pkg::alu_op_t'({f7_alt && funct3 == 3'b101, funct3});
				wr_en  = 1'b1;
			end
			rv_pipe_pkg::op_load: begin
				wr_en  = 1'b1;
				wb_sel = rv_pipe_pkg::wb_load;
			end
			rv_pipe_pkg::op_store: begin
				imm      = imm_s;
				is_store = 1'b1;
			end
			rv_pipe_pkg::op_lui: begin
				imm    = imm_u;
				wr_en  = 1'b1;
				wb_sel = rv_pipe_pkg::wb_imm;      // Bypasses the ALU
			end
			rv_pipe_pkg::op_auipc: begin
				imm     = imm_u;
				sel_opa = 1'b0;                    // PC plus immediate
				wr_en   = 1'b1;
			end
			default: ;
		endcase

		a_wr_xor_store: assert (!(wr_en && is_store))
			else $error("Decoder drove wr_en and is_store together");
	end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  wr_en,
	input  rv_pipe_pkg::reg_idx_t wr_idx,
	input  rv_pipe_pkg::word_t    wr_data,
	input  rv_pipe_pkg::reg_idx_t rs1_idx,
	input  rv_pipe_pkg::reg_idx_t rs2_idx,
	output rv_pipe_pkg::word_t    rs1_data,
	output rv_pipe_pkg::word_t    rs2_data
);

	rv_pipe_pkg::word_t regs [32];

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;           // x0 never written
		end
	end

	// Combinational reads, WB bypass is done in the core
	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
	input  rv_pipe_pkg::word_t   op_a,
	input  rv_pipe_pkg::word_t   op_b,
	input  rv_pipe_pkg::alu_op_t alu_op,
	output rv_pipe_pkg::word_t   res
);

	logic [4:0] shamt;

	assign shamt = op_b[4:0];                // RV32 shift amount

	always_comb begin
		case (alu_op)
			rv_pipe_pkg::alu_add:  res = op_a + op_b;
			rv_pipe_pkg::alu_sub:  res = op_a - op_b;
			rv_pipe_pkg::alu_sll:  res = op_a << shamt;
			rv_pipe_pkg::alu_slt:
				res = rv_pipe_pkg::word_t'($signed(op_a) < $signed(op_b));
			rv_pipe_pkg::alu_sltu:
				res = rv_pipe_pkg::word_t'(op_a < op_b);
			rv_pipe_pkg::alu_xor:  res = op_a ^ op_b;
			rv_pipe_pkg::alu_srl:  res = op_a >> shamt;
			rv_pipe_pkg::alu_sra:
				res = rv_pipe_pkg::word_t'($signed(op_a) >>> shamt);   // Keeps sign bit
			rv_pipe_pkg::alu_or:   res = op_a | op_b;
			rv_pipe_pkg::alu_and:  res = op_a & op_b;
			default:               res = op_a + op_b;
		endcase
	end

endmodule

// ==== store_align.sv ====
`timescale 1ns/1ps

module store_align (
	input  rv_pipe_pkg::word_t     rs2_data,
	input  logic [1:0]             byte_offset,
	input  rv_pipe_pkg::mem_size_t mem_size,
	input  logic                   is_store,
	output rv_pipe_pkg::word_t     wdata,
	output rv_pipe_pkg::byte_en_t  byte_we
);

	rv_pipe_pkg::byte_en_t lanes;

	always_comb begin
		case (mem_size)
			rv_pipe_pkg::size_b: begin
				wdata = {4{rs2_data[7:0]}};               // Byte on every lane
				lanes = 4'b0001 << byte_offset;
			end
			rv_pipe_pkg::size_h: begin
				wdata = {2{rs2_data[15:0]}};
				lanes = 4'b0011 << {byte_offset[1], 1'b0};  // Halfword aligned
			end
			default: begin
				wdata = rs2_data;
				lanes = 4'b1111;
			end
		endcase
	end

	assign byte_we = is_store ? lanes : '0;

endmodule

// ==== load_align.sv ====
`timescale 1ns/1ps

module load_align (
	input  rv_pipe_pkg::word_t     rdata,
	input  logic [1:0]             byte_offset,
	input  rv_pipe_pkg::mem_size_t mem_size,
	output rv_pipe_pkg::word_t     load_data
);

	rv_pipe_pkg::word_t shifted;

	// Addressed byte or half moved down to lane 0
	assign shifted = rdata >> {byte_offset, 3'b000};

	always_comb begin
		case (mem_size)
			rv_pipe_pkg::size_b:  load_data = {{24{shifted[7]}}, shifted[7:0]};
			rv_pipe_pkg::size_h:  load_data = {{16{shifted[15]}}, shifted[15:0]};
			rv_pipe_pkg::size_bu: load_data = {24'b0, shifted[7:0]};
			rv_pipe_pkg::size_hu: load_data = {16'b0, shifted[15:0]};
			rv_pipe_pkg::size_w:  load_data = rdata;
			default:              load_data = rdata;    // No other load widths
		endcase
	end

endmodule

// ==== datamem.sv ====
`timescale 1ns/1ps

module datamem (
	input  logic                    CLK,
	dmem_port_if.mem                cpu,
	input  rv_pipe_pkg::byte_en_t   con_write,
	input  rv_pipe_pkg::dmem_addr_t con_addr,
	input  rv_pipe_pkg::word_t      con_in,
	output rv_pipe_pkg::word_t      con_out
);

	rv_pipe_pkg::word_t mem [rv_pipe_pkg::dmem_depth];

	//////////////////////////////////////////////////
	// Write ports, con port last so it wins a lane
	//////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		for (int b = 0; b < 4; b++) begin
			if (cpu.byte_we[b])
				mem[cpu.addr][8*b +: 8] <= cpu.wdata[8*b +: 8];
			if (con_write[b])
				mem[con_addr][8*b +: 8] <= con_in[8*b +: 8];   // Overrides core on collision
		end
	end

	// Con read registered, old word on a same-edge write
	always_ff @(posedge CLK) begin
		con_out <= mem[con_addr];
	end

	assign cpu.rdata = mem[cpu.addr];         // Core read, no clock

	// Once the pipeline reset has cleared the enables they stay known
	a_byte_we_known: assert property (@(posedge CLK)
		!$isunknown(cpu.byte_we) |=> !$isunknown(cpu.byte_we))
		else $error("Core byte write enable went unknown");

endmodule

// ==== core.sv ====
`timescale 1ns/1ps

module core (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  rv_pipe_pkg::byte_en_t   con_write,   // From protocol controllers
	input  rv_pipe_pkg::dmem_addr_t con_addr,
	input  rv_pipe_pkg::word_t      con_in,
	output rv_pipe_pkg::word_t      con_out      // Valid one cycle after con_addr
);

	// Final register value of an instruction, by its write-back source
	function automatic rv_pipe_pkg::word_t wb_mux(
		input rv_pipe_pkg::wb_sel_t sel,
		input rv_pipe_pkg::pc_t     pc4,
		input rv_pipe_pkg::word_t   alu_res,
		input rv_pipe_pkg::word_t   imm,
		input rv_pipe_pkg::word_t   load_data
	);
		case (sel)
			rv_pipe_pkg::wb_pc4: return rv_pipe_pkg::word_t'(pc4);   // Zero extended
			rv_pipe_pkg::wb_alu: return alu_res;
			rv_pipe_pkg::wb_imm: return imm;
			default:             return load_data;
		endcase
	endfunction

	// IF
	rv_pipe_pkg::pc_t   pc, if_pc4;
	rv_pipe_pkg::word_t if_inst;
	rv_pipe_pkg::word_t rom [rv_pipe_pkg::imem_depth];
	// ID
	rv_pipe_pkg::pc_t      id_pc, id_pc4;
	rv_pipe_pkg::word_t    id_inst, id_imm, id_rf_rs1, id_rf_rs2;
	rv_pipe_pkg::word_t    id_rs1_val, id_rs2_val, id_opa, id_opb;
	rv_pipe_pkg::reg_idx_t id_rs1, id_rs2, id_rd;
	rv_pipe_pkg::alu_op_t  id_alu_op;
	rv_pipe_pkg::mem_size_t id_mem_size;
	rv_pipe_pkg::wb_sel_t  id_wb_sel;
	logic id_sel_opa, id_sel_opb, id_dec_wr_en, id_wr_en, id_is_store;
	// EXE
	rv_pipe_pkg::pc_t      exe_pc4;
	rv_pipe_pkg::word_t    exe_opa, exe_opb, exe_rs2_val, exe_imm;
	rv_pipe_pkg::word_t    exe_alu_res, exe_wdata, exe_fwd;
	rv_pipe_pkg::reg_idx_t exe_rd;
	rv_pipe_pkg::alu_op_t  exe_alu_op;
	rv_pipe_pkg::mem_size_t exe_mem_size;
	rv_pipe_pkg::wb_sel_t  exe_wb_sel;
	rv_pipe_pkg::byte_en_t exe_byte_we;
	logic exe_wr_en, exe_is_store;
	// MEM
	rv_pipe_pkg::pc_t      mem_pc4;
	rv_pipe_pkg::word_t    mem_alu_res, mem_wdata, mem_imm, mem_load_data, mem_data;
	rv_pipe_pkg::reg_idx_t mem_rd;
	rv_pipe_pkg::mem_size_t mem_msize;
	rv_pipe_pkg::wb_sel_t  mem_wb_sel;
	rv_pipe_pkg::byte_en_t mem_byte_we;
	logic mem_wr_en;
	// WB
	rv_pipe_pkg::word_t    wb_data;                 // Value being written
	rv_pipe_pkg::reg_idx_t wb_rd;
	logic wb_wr_en;

	dmem_port_if dmem_bus ();

	//////////////////////////////////////////////////
	// IF stage
	//////////////////////////////////////////////////
	initial $readmemh("program.hex", rom);

	assign if_pc4  = pc + rv_pipe_pkg::pc_t'(4);    // No branches, always +4
	assign if_inst = rom[pc[rv_pipe_pkg::pc_w-1:2]];

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			pc      <= '0;
			id_inst <= '0;                          // Opcode 0 decodes as no-op
		end else begin
			pc      <= if_pc4;
			id_inst <= if_inst;
		end
		id_pc  <= pc;
		id_pc4 <= if_pc4;
	end

	//////////////////////////////////////////////////
	// ID stage
	//////////////////////////////////////////////////
	assign id_rs1 = id_inst[19:15];
	assign id_rs2 = id_inst[24:20];
	assign id_rd  = id_inst[11:7];

	decoder u_decoder (
		.inst(id_inst), .alu_op(id_alu_op), .sel_opa(id_sel_opa), .sel_opb(id_sel_opb),
		.wr_en(id_dec_wr_en), .is_store(id_is_store), .mem_size(id_mem_size),
		.wb_sel(id_wb_sel), .imm(id_imm)
	);

	regfile u_regfile (
		.CLK(CLK), .rst_n(rst_n),
		.wr_en(wb_wr_en), .wr_idx(wb_rd), .wr_data(wb_data),
		.rs1_idx(id_rs1), .rs2_idx(id_rs2), .rs1_data(id_rf_rs1), .rs2_data(id_rf_rs2)
	);

	// Writes to x0 dropped here, so forwarding never matches x0
	assign id_wr_en = id_dec_wr_en && (id_rd != '0);

	// Load data not ready in EXE, ALU result stands in
	assign exe_fwd = wb_mux(exe_wb_sel, exe_pc4, exe_alu_res, exe_imm, exe_alu_res);

	// Youngest producer wins
	assign id_rs1_val = (exe_wr_en && exe_rd == id_rs1) ? exe_fwd :
	                    (mem_wr_en && mem_rd == id_rs1) ? mem_data :
	                    (wb_wr_en  && wb_rd  == id_rs1) ? wb_data  : id_rf_rs1;
	assign id_rs2_val = (exe_wr_en && exe_rd == id_rs2) ? exe_fwd :
	                    (mem_wr_en && mem_rd == id_rs2) ? mem_data :
	                    (wb_wr_en  && wb_rd  == id_rs2) ? wb_data  : id_rf_rs2;

	assign id_opa = id_sel_opa ? id_rs1_val : rv_pipe_pkg::word_t'(id_pc);   // PC for auipc
	assign id_opb = id_sel_opb ? id_imm : id_rs2_val;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			exe_wr_en    <= 1'b0;
			exe_is_store <= 1'b0;
		end else begin
			exe_wr_en    <= id_wr_en;
			exe_is_store <= id_is_store;
		end
		exe_pc4      <= id_pc4;
		exe_opa      <= id_opa;
		exe_opb      <= id_opb;
		exe_rs2_val  <= id_rs2_val;                 // Store data, already forwarded
		exe_imm      <= id_imm;
		exe_rd       <= id_rd;
		exe_alu_op   <= id_alu_op;
		exe_mem_size <= id_mem_size;
		exe_wb_sel   <= id_wb_sel;
	end

	//////////////////////////////////////////////////
	// EXE stage
	//////////////////////////////////////////////////
	alu u_alu (.op_a(exe_opa), .op_b(exe_opb), .alu_op(exe_alu_op), .res(exe_alu_res));

	store_align u_store_align (
		.rs2_data(exe_rs2_val), .byte_offset(exe_alu_res[1:0]), .mem_size(exe_mem_size),
		.is_store(exe_is_store), .wdata(exe_wdata), .byte_we(exe_byte_we)
	);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mem_wr_en   <= 1'b0;
			mem_byte_we <= '0;
		end else begin
			mem_wr_en   <= exe_wr_en;
			mem_byte_we <= exe_byte_we;
		end
		mem_pc4     <= exe_pc4;
		mem_alu_res <= exe_alu_res;
		mem_wdata   <= exe_wdata;
		mem_imm     <= exe_imm;
		mem_rd      <= exe_rd;
		mem_msize   <= exe_mem_size;
		mem_wb_sel  <= exe_wb_sel;
	end

	//////////////////////////////////////////////////
	// MEM stage
	//////////////////////////////////////////////////
	assign dmem_bus.addr    = mem_alu_res[rv_pipe_pkg::dmem_aw+1:2];   // Byte to word address
	assign dmem_bus.wdata   = mem_wdata;
	assign dmem_bus.byte_we = mem_byte_we;

	datamem u_datamem (
		.CLK(CLK), .cpu(dmem_bus.mem),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out)
	);

	load_align u_load_align (
		.rdata(dmem_bus.rdata), .byte_offset(mem_alu_res[1:0]), .mem_size(mem_msize),
		.load_data(mem_load_data)
	);

	assign mem_data = wb_mux(mem_wb_sel, mem_pc4, mem_alu_res, mem_imm, mem_load_data);

	// MEM/WB keeps only the selected value
	always_ff @(posedge CLK) begin
		if (!rst_n)
			wb_wr_en <= 1'b0;
		else
			wb_wr_en <= mem_wr_en;
		wb_data <= mem_data;
		wb_rd   <= mem_rd;
	end

	// The x0 filter in ID must hold all the way to write-back
	a_no_x0_write: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_wr_en |-> wb_rd != '0)
		else $error("Register write to x0 reached the register file");

endmodule

// ==== tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

	localparam rv_pipe_pkg::word_t done_marker  = 32'h600d_f00d;
	localparam rv_pipe_pkg::word_t fill_pattern = 32'h1122_3344;   // Under the sb and sh
	localparam rv_pipe_pkg::word_t auipc_pc     = 32'd268;          // ROM index 67
	localparam int                 poll_limit   = 500;              // Cycles

	logic                    clk;
	logic                    rst_n;
	rv_pipe_pkg::byte_en_t   con_write;
	rv_pipe_pkg::dmem_addr_t con_addr;
	rv_pipe_pkg::word_t      con_in;
	rv_pipe_pkg::word_t      con_out;

	rv_pipe_pkg::word_t in_a, in_b, in_c, in_d;   // Random inputs at words 0 to 3

	core uut (
		.CLK(clk), .rst_n(rst_n),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;                    // 8 ns period
	end

	//////////////////////////////////////////////////
	// ISA extension rules
	//////////////////////////////////////////////////
	function automatic rv_pipe_pkg::word_t sext_byte(input logic [7:0] v);
		return {{24{v[7]}}, v};
	endfunction

	function automatic rv_pipe_pkg::word_t sext_half(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	//////////////////////////////////////////////////
	// Con port access
	//////////////////////////////////////////////////
	// Write lands on the next edge
	task automatic write_con(input rv_pipe_pkg::dmem_addr_t addr,
			input rv_pipe_pkg::word_t data, input rv_pipe_pkg::byte_en_t be);
		@(posedge clk);
		con_write <= be;
		con_addr  <= addr;
		con_in    <= data;
	endtask

	// Registered read, sampled mid-cycle once settled
	task automatic read_con(input rv_pipe_pkg::dmem_addr_t addr,
			output rv_pipe_pkg::word_t data);
		@(posedge clk);
		con_write <= '0;
		con_addr  <= addr;
		@(posedge clk);                           // Address captured here
		@(negedge clk);
		data = con_out;
	endtask

	task automatic check_word(input rv_pipe_pkg::dmem_addr_t addr,
			input rv_pipe_pkg::word_t expected);
		rv_pipe_pkg::word_t got;
		read_con(addr, got);
		assert (got === expected) else begin
			$display("MISMATCH con_out word %0d: expected %08h, got %08h", addr, expected, got);
			$display("Regression failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial begin
		rv_pipe_pkg::word_t got;
		rv_pipe_pkg::word_t t1, t2, t3;          // Dependent chain, sequential order
		rv_pipe_pkg::word_t lb_sum, lbu_sum, lh_sum, lhu_sum;
		int                 waited;
		logic               done;

		rst_n     <= 1'b0;
		con_write <= '0;
		con_addr  <= '0;
		con_in    <= '0;
		void'($urandom(32'h1ce7));
		in_a = $urandom();
		in_b = $urandom();
		in_c = $urandom();
		in_d = $urandom();

		repeat (5) @(posedge clk);

		// Core stays in reset while the con port loads memory
		write_con(0, in_a, 4'hf);
		write_con(1, in_b, 4'hf);
		write_con(2, in_c, 4'hf);
		write_con(3, in_d, 4'hf);
		for (int i = 16; i <= 40; i++)
			write_con(rv_pipe_pkg::dmem_addr_t'(i), '0, 4'hf);
		write_con(37, fill_pattern, 4'hf);
		write_con(38, fill_pattern, 4'hf);
		@(posedge clk);
		con_write <= '0;
		rst_n     <= 1'b1;

		// Marker is the program's last store
		waited = 0;
		done   = 1'b0;
		while (!done && waited < poll_limit) begin
			read_con(63, got);
			waited += 2;
			done = (got === done_marker);
		end
		if (!done) begin
			$display("Timeout: program never stored the done marker within %0d cycles",
				poll_limit);
			$display("Regression failed");
			$fatal(1, "Program did not finish");
		end

		// R-type, shift amount from low 5 bits
		check_word(16, in_a + in_b);
		check_word(17, in_a - in_b);
		check_word(18, in_a << in_b[4:0]);
		check_word(19, rv_pipe_pkg::word_t'($signed(in_a) < $signed(in_b)));
		check_word(20, rv_pipe_pkg::word_t'(in_a < in_b));
		check_word(21, in_a ^ in_b);
		check_word(22, in_a >> in_b[4:0]);
		check_word(23, rv_pipe_pkg::word_t'($signed(in_a) >>> in_b[4:0]));
		check_word(24, in_a | in_b);
		check_word(25, in_a & in_b);
		// I-type
		check_word(26, in_a - 32'd100);
		check_word(27, rv_pipe_pkg::word_t'($signed(in_a) < -32'sd1000));
		check_word(28, in_b ^ 32'h0000_0555);
		check_word(29, in_c << 7);
		check_word(30, rv_pipe_pkg::word_t'($signed(in_d) >>> 13));

		// Chain at distances 1, 2 and 3
		t1 = in_a + in_b;
		t2 = t1 ^ in_c;
		t3 = t2 - t1;
		check_word(31, t3 ^ t1);

		// Loads of every lane of in_d, summed per kind
		lb_sum  = '0;
		lbu_sum = '0;
		for (int i = 0; i < 4; i++) begin
			lb_sum  += sext_byte(in_d[8*i +: 8]);
			lbu_sum += rv_pipe_pkg::word_t'(in_d[8*i +: 8]);
		end
		lh_sum  = sext_half(in_d[15:0]) + sext_half(in_d[31:16]);
		lhu_sum = rv_pipe_pkg::word_t'(in_d[15:0]) + rv_pipe_pkg::word_t'(in_d[31:16]);
		check_word(32, lb_sum);
		check_word(33, lbu_sum);
		check_word(34, lh_sum);
		check_word(35, lhu_sum);

		// Partial stores, other lanes keep the pattern
		check_word(37, {fill_pattern[31:16], in_a[7:0], fill_pattern[7:0]});
		check_word(38, {in_b[15:0], fill_pattern[15:0]});
		check_word(39, 32'habcd_e000);
		check_word(40, 32'h1234_5000 + auipc_pc);

		// Word 36 untouched by the program, then merged by the con port
		check_word(36, '0);
		write_con(36, 32'hcafe_babe, 4'b1010);
		check_word(36, 32'hca00_ba00);
		write_con(36, 32'h1234_5678, 4'b0001);
		check_word(36, 32'hca00_ba78);

		$display("Regression passed");
		$finish;
	end

endmodule

// ==== program.hex ====
// ROM image, one instruction word per line from index 0 (PC = 4 * index)
// Text after each word is its assembly; results go to byte 64 upward
00002083 // lw   x1, 0(x0)
00402103 // lw   x2, 4(x0)
00802183 // lw   x3, 8(x0)
00c02203 // lw   x4, 12(x0)
002082b3 // add  x5, x1, x2
04502023 // sw   x5, 64(x0)
402082b3 // sub  x5, x1, x2
04502223 // sw   x5, 68(x0)
002092b3 // sll  x5, x1, x2
04502423 // sw   x5, 72(x0)
0020a2b3 // slt  x5, x1, x2
04502623 // sw   x5, 76(x0)
0020b2b3 // sltu x5, x1, x2
04502823 // sw   x5, 80(x0)
0020c2b3 // xor  x5, x1, x2
04502a23 // sw   x5, 84(x0)
0020d2b3 // srl  x5, x1, x2
04502c23 // sw   x5, 88(x0)
4020d2b3 // sra  x5, x1, x2
04502e23 // sw   x5, 92(x0)
0020e2b3 // or   x5, x1, x2
06502023 // sw   x5, 96(x0)
0020f2b3 // and  x5, x1, x2
06502223 // sw   x5, 100(x0)
f9c08293 // addi x5, x1, -100
06502423 // sw   x5, 104(x0)
c180a293 // slti x5, x1, -1000
06502623 // sw   x5, 108(x0)
55514293 // xori x5, x2, 0x555
06502823 // sw   x5, 112(x0)
00719293 // slli x5, x3, 7
06502a23 // sw   x5, 116(x0)
40d25293 // srai x5, x4, 13
06502c23 // sw   x5, 120(x0)
00208533 // add  x10, x1, x2
003545b3 // xor  x11, x10, x3
40a58633 // sub  x12, x11, x10
00a646b3 // xor  x13, x12, x10
06d02e23 // sw   x13, 124(x0)
00c00303 // lb   x6, 12(x0)
00d00383 // lb   x7, 13(x0)
00e00403 // lb   x8, 14(x0)
00f00483 // lb   x9, 15(x0)
00730333 // add  x6, x6, x7
00940433 // add  x8, x8, x9
00830333 // add  x6, x6, x8
08602023 // sw   x6, 128(x0)
00c04303 // lbu  x6, 12(x0)
00d04383 // lbu  x7, 13(x0)
00e04403 // lbu  x8, 14(x0)
00f04483 // lbu  x9, 15(x0)
00730333 // add  x6, x6, x7
00940433 // add  x8, x8, x9
00830333 // add  x6, x6, x8
08602223 // sw   x6, 132(x0)
00c01303 // lh   x6, 12(x0)
00e01383 // lh   x7, 14(x0)
00c05403 // lhu  x8, 12(x0)
00e05483 // lhu  x9, 14(x0)
00730333 // add  x6, x6, x7
00940433 // add  x8, x8, x9
08602423 // sw   x6, 136(x0)
08802623 // sw   x8, 140(x0)
08100aa3 // sb   x1, 149(x0)
08201d23 // sh   x2, 154(x0)
abcde2b7 // lui  x5, 0xabcde
08502e23 // sw   x5, 156(x0)
12345297 // auipc x5, 0x12345
0a502023 // sw   x5, 160(x0)
600df2b7 // lui  x5, 0x600df
00d28293 // addi x5, x5, 13
0e502e23 // sw   x5, 252(x0)

// ==== rv_pipe.f ====
rv_pipe_pkg.sv
dmem_port_if.sv
decoder.sv
regfile.sv
alu.sv
store_align.sv
load_align.sv
datamem.sv
core.sv
tb_core.sv

// ==== run_rv_pipe.sh ====
#!/bin/sh
# Build and run tb_core with Verilator from the project root
cd "$(dirname "$0")" || exit 1

build_log=build_rv_pipe.log
sim_log=sim_rv_pipe.log

verilator --binary --timing --assert --top-module tb_core -Mdir obj_dir \
	-o vtb_core -f rv_pipe.f > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/vtb_core > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression passed" "$sim_log"; then
	exit 0
else
	echo "Pass message not found in $sim_log"
	exit 1
fi
